//--- files.f
+incdir+.
rss_pkg.sv
rss_ifc.sv
hash_acc.sv
tuple_extract.sv
rss_regs.sv
rss_indirection.sv
rss_hash_top.sv
rss_clk_gen.sv
rss_properties.sv
rss_tb.sv

//--- hash_acc.sv
// Toeplitz hash accumulator
// Collects tuple bytes at a running offset and hashes them against the key.
// The hash is combinational from the collected bytes, so it follows the
// last registered feed by one cycle
`timescale 1ns/1ps
`include "rss_params.svh"

module hash_acc #(
    parameter int HASH_WIDTH = `RSS_HASH_BYTES
) (
    input  logic        clk,
    input  logic        rst,
    hash_feed_if.acc    feed,
    rss_cfg_if.key_sink cfg,
    output logic [31:0] hash_out
);

    localparam int OFFSET_WIDTH = $clog2(HASH_WIDTH);

    logic [HASH_WIDTH*8-1:0] data_q;   // Byte i of the tuple sits at bits i*8+7:i*8
    logic [OFFSET_WIDTH-1:0] offset_q; // Next free byte position

    // Each set data bit XORs in the 32-bit key window that starts at its bit index
    function automatic logic [31:0] toeplitz(input logic [HASH_WIDTH*8-1:0] data,
                                             input logic [(HASH_WIDTH+4)*8-1:0] key);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < HASH_WIDTH; i++) begin
            for (int j = 0; j < 8; j++) begin
                if (data[i*8 + (7-j)]) begin // Bit 7 of a byte is its first bit
                    acc = acc ^ key[(HASH_WIDTH+4)*8 - 32 - i*8 - j +: 32];
                end
            end
        end
        return acc;
    endfunction

    assign hash_out = toeplitz(data_q, cfg.key); // Unfilled bytes are zero and add nothing

    always_ff @(posedge clk) begin
        if (rst || feed.clear) begin
            data_q   <= '0;
            offset_q <= '0;
        end else if (feed.valid) begin
            case (feed.len)
                rss_pkg::LEN1: begin
                    data_q[offset_q*8 +: 8] <= feed.data[7:0];
                    offset_q                <= offset_q + OFFSET_WIDTH'(1);
                end
                rss_pkg::LEN2: begin
                    data_q[offset_q*8 +: 16] <= feed.data[15:0];
                    offset_q                 <= offset_q + OFFSET_WIDTH'(2);
                end
                default: begin
                    data_q[offset_q*8 +: 32] <= feed.data; // Full word, the common case
                    offset_q                 <= offset_q + OFFSET_WIDTH'(4);
                end
            endcase
        end
    end

endmodule

//--- rss_clk_gen.sv
// Testbench clock source
// Free-running clock that starts low
`timescale 1ns/1ps

module rss_clk_gen #(
    parameter int PERIOD = 40 // Clock period in ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk; // Half period per phase
    end

endmodule

//--- rss_hash_top.sv
// RSS hash unit top level
// IPv4 header words in, Toeplitz hash and receive queue out, with the key
// and indirection table programmed over Wishbone classic
`timescale 1ns/1ps
`include "rss_params.svh"

module rss_hash_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [31:0]                hdr_data,
    input  logic                       hdr_valid,
    input  logic                       hdr_sop,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [7:0]                 wb_adr,
    input  logic [31:0]                wb_wdata,
    output logic [31:0]                wb_rdata,
    output logic                       wb_ack,
    output logic                       result_valid,
    output logic [31:0]                result_hash,
    output logic [`RSS_QUEUE_BITS-1:0] result_queue
);

    hash_feed_if feed_if ();
    rss_cfg_if   cfg_if ();

    logic [31:0] hash; // Running hash of the current tuple

    tuple_extract u_extract (.clk, .rst, .hdr_data, .hdr_valid, .hdr_sop, .feed(feed_if.src));

    hash_acc u_acc (.clk, .rst, .feed(feed_if.acc), .cfg(cfg_if.key_sink), .hash_out(hash));

    rss_regs u_regs (.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata,
                     .wb_ack, .cfg(cfg_if.master));

    // The last flag skips the accumulator and goes straight to the result stage
    rss_indirection u_indir (.clk, .rst, .feed_last(feed_if.last), .hash_in(hash),
                             .cfg(cfg_if.tbl), .result_valid, .result_hash, .result_queue);

endmodule

//--- rss_ifc.sv
// RSS internal interfaces
// hash_feed_if carries tuple bytes from the extractor to the accumulator,
// rss_cfg_if carries the key and table writes out of the register block
`timescale 1ns/1ps
`include "rss_params.svh"

interface hash_feed_if;
    logic [31:0]        data;  // First byte of the stream in bits 7:0
    rss_pkg::feed_len_e len;
    logic               valid;
    logic               clear; // Wins over valid in the same cycle
    logic               last;  // Final feed of a tuple

    modport src (output data, len, valid, clear, last);
    modport acc (input data, len, valid, clear);
endinterface

interface rss_cfg_if;
    logic [`RSS_KEY_WORDS*32-1:0]  key;       // Key word 0 in the top bits
    logic                          tbl_we;
    logic [`RSS_TBL_BITS-1:0]      tbl_addr;
    logic [`RSS_QUEUE_BITS-1:0]    tbl_queue;

    modport master   (output key, tbl_we, tbl_addr, tbl_queue);
    modport key_sink (input key);
    modport tbl      (input tbl_we, tbl_addr, tbl_queue);
endinterface

//--- rss_indirection.sv
// RSS indirection stage
// Holds the 64-entry queue table and, one cycle after the last feed of a
// tuple, captures the finished hash with the queue at its low index bits
`timescale 1ns/1ps
`include "rss_params.svh"

module rss_indirection (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       feed_last,
    input  logic [31:0]                hash_in,
    rss_cfg_if.tbl                     cfg,
    output logic                       result_valid,
    output logic [31:0]                result_hash,
    output logic [`RSS_QUEUE_BITS-1:0] result_queue
);

    localparam int TBL_DEPTH = 1 << `RSS_TBL_BITS;

    logic [`RSS_QUEUE_BITS-1:0] tbl_q [TBL_DEPTH]; // Queue per low hash index
    logic                       last_q;            // Hash is settled this cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TBL_DEPTH; i++) begin
                tbl_q[i] <= '0; // Every hash maps to queue 0 until programmed
            end
        end else if (cfg.tbl_we) begin
            tbl_q[cfg.tbl_addr] <= cfg.tbl_queue;
        end
    end

    // Sampled before a following clear can reach the accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            last_q       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            last_q       <= feed_last;
            result_valid <= last_q; // One-cycle strobe per tuple
        end
    end

    always_ff @(posedge clk) begin
        if (last_q) begin
            result_hash  <= hash_in;
            result_queue <= tbl_q[hash_in[`RSS_TBL_BITS-1:0]];
        end
    end

endmodule

//--- rss_params.svh
// RSS hash unit sizing constants
// Key length, accumulator depth and indirection table geometry
`ifndef RSS_PARAMS_SVH
`define RSS_PARAMS_SVH

`define RSS_HASH_BYTES 36 // Accumulator depth in bytes, enough for any IPv4 tuple
`define RSS_KEY_WORDS  10 // Secret key in 32-bit words, hash bytes plus four

`define RSS_TBL_BITS   6  // Indirection index width, 64 entries
`define RSS_QUEUE_BITS 4  // Receive queue number width

`endif

//--- rss_pkg.sv
// RSS shared types
// IPv4 header word views, L4 protocol codes and the hash feed byte count
package rss_pkg;

    typedef struct packed {
        logic [3:0]  version;   // Always 4 for headers that get hashed
        logic [3:0]  ihl;       // Header length in 32-bit words
        logic [7:0]  tos;
        logic [15:0] total_len;
    } ipv4_w0_t;

    typedef struct packed {
        logic [7:0]  ttl;
        logic [7:0]  protocol;  // Selects whether ports join the tuple
        logic [15:0] checksum;
    } ipv4_w2_t;

    // Same header word seen as word 0 or word 2 of the header
    typedef union packed {
        ipv4_w0_t w0;
        ipv4_w2_t w2;
    } ipv4_word_u;

    localparam logic [7:0] PROTO_TCP = 8'd6;
    localparam logic [7:0] PROTO_UDP = 8'd17;

    typedef enum logic [1:0] {
        LEN4 = 2'd0, // Any code other than 1 or 2 also means four bytes
        LEN1 = 2'd1,
        LEN2 = 2'd2
    } feed_len_e;

endpackage

//--- rss_properties.sv
// RSS hash unit port assertions
// Wishbone acknowledge discipline and the result strobe out of reset
`timescale 1ns/1ps

module rss_properties (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic result_valid
);

    // An acknowledge only answers a live request
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb)) else $error("wb_ack outside a requested cycle");

    a_ack_gap: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack) else $error("wb_ack high on two cycles in a row");

    a_valid_reset: assert property (@(posedge clk)
        rst |=> !result_valid) else $error("result_valid high after reset");

endmodule

bind rss_hash_top rss_properties u_props (.clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .result_valid);

//--- rss_regs.sv
// RSS configuration registers
// Wishbone classic slave holding the 40-byte Toeplitz key and passing
// indirection table writes through as single-cycle write strobes.
// Words 0 to 9 are the key, words 64 to 127 the write-only table
`timescale 1ns/1ps
`include "rss_params.svh"

module rss_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [7:0]  wb_adr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_rdata,
    output logic        wb_ack,
    rss_cfg_if.master   cfg
);

    logic [`RSS_KEY_WORDS*32-1:0] key_q; // Key word 0 in the top 32 bits
    logic                         take;  // Request accepted this cycle
    logic                         key_hit;
    logic                         tbl_hit;
    int                           key_lsb;

    // The cycle after an ack is never accepted, giving one transfer per two cycles
    assign take    = wb_cyc && wb_stb && !wb_ack;
    assign key_hit = int'(wb_adr) < `RSS_KEY_WORDS;
    assign tbl_hit = wb_adr[7:6] == 2'b01;
    assign key_lsb = (`RSS_KEY_WORDS - 1 - int'(wb_adr)) * 32;

    assign cfg.key       = key_q;
    assign cfg.tbl_we    = take && wb_we && tbl_hit; // Table writes land with the ack edge
    assign cfg.tbl_addr  = wb_adr[`RSS_TBL_BITS-1:0];
    assign cfg.tbl_queue = wb_wdata[`RSS_QUEUE_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            key_q  <= '0;
        end else begin
            wb_ack <= take;
            if (take && wb_we && key_hit) begin
                key_q[key_lsb +: 32] <= wb_wdata;
            end
        end
    end

    // Read data lines up with the ack, table and unmapped words read as zero
    always_ff @(posedge clk) begin
        if (take) begin
            if (key_hit) begin
                wb_rdata <= key_q[key_lsb +: 32];
            end else begin
                wb_rdata <= '0;
            end
        end
    end

endmodule

//--- rss_tb.sv
// RSS hash unit testbench
// Programs key and indirection table over Wishbone, streams IPv4 headers
// and checks each hash and queue against a Toeplitz reference model
`timescale 1ns/1ps
`include "rss_params.svh"

module rss_tb;

    localparam int NUM_TESTS   = 6;
    localparam int CYCLE_LIMIT = 200 * NUM_TESTS + 100; // Run length bound in cycles
    localparam int KEY_TOP     = `RSS_KEY_WORDS * 32 - 1;
    localparam logic [KEY_TOP:0] KEY = {                 // Widely published RSS key
        128'h6d5a56da_255b0ec2_4167253d_43a38fb0,
        128'hd0ca2bcb_ae7b30b4_77cb2da3_8030f20c,
        64'h6a42b73b_beac01fa};

    logic                       clk;
    logic                       rst;
    logic [31:0]                hdr_data;
    logic                       hdr_valid;
    logic                       hdr_sop;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [7:0]                 wb_adr;
    logic [31:0]                wb_wdata;
    logic [31:0]                wb_rdata;
    logic                       wb_ack;
    logic                       result_valid;
    logic [31:0]                result_hash;
    logic [`RSS_QUEUE_BITS-1:0] result_queue;
    logic [KEY_TOP:0]           key_model;                     // Key as written
    logic [`RSS_QUEUE_BITS-1:0] tbl_model [1 << `RSS_TBL_BITS]; // Table as written
    logic [31:0]                exp_hash [$];                  // Pending results, oldest first
    logic [`RSS_QUEUE_BITS-1:0] exp_queue [$];
    int                         errors;
    int                         ack_count;
    int                         cycles;

    rss_clk_gen #(.PERIOD(40)) u_clk (.clk);
    rss_hash_top uut (.*);

    // Every set tuple bit XORs in the 32 key bits that start at its position
    function automatic logic [31:0] rss_ref_hash(input logic [95:0] tuple, input int nbits);
        logic [31:0] h;
        h = '0;
        for (int p = 0; p < nbits; p++) begin
            if (tuple[95 - p]) begin
                h = h ^ key_model[KEY_TOP - p -: 32];
            end
        end
        return h;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wb_xfer(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
        int wait_cnt;
        @(posedge clk);
        #2;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_wdata} = {1'b1, 1'b1, we, adr, wdata};
        wait_cnt = 0;
        do begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end while (!wb_ack && wait_cnt < 16);
        if (!wb_ack) begin
            $display("Wishbone access to word %0d got no acknowledge", adr);
            errors++;
        end
        rdata = wb_rdata;
        @(posedge clk); // The slave's ack is taken on this edge
        #2;
        {wb_cyc, wb_stb, wb_we} = 3'b000; // Release after the edge that takes the ack
    endtask

    task automatic put_word(input logic [31:0] data, input logic sop, input int gap);
        repeat (gap) begin
            @(posedge clk);
            #2;
            {hdr_valid, hdr_sop} = 2'b00;
        end
        @(posedge clk);
        #2;
        {hdr_valid, hdr_sop, hdr_data} = {1'b1, sop, data};
    endtask

    // Words 0 to IHL, source in word 3, destination in word 4, ports in word IHL
    task automatic send_hdr(input logic [3:0] ver, input logic [3:0] ihl, input logic [7:0] proto,
                            input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] ports, input int gap_max);
        logic [31:0] h;
        logic [31:0] word;
        h = rss_ref_hash({src, dst, ports}, (proto == 8'd6 || proto == 8'd17) ? 96 : 64);
        if (ver == 4'd4) begin
            exp_hash.push_back(h);
            exp_queue.push_back(tbl_model[h[`RSS_TBL_BITS-1:0]]);
        end
        put_word({ver, ihl, 8'h00, 16'd60}, 1'b1, 0); // Always straight after the last word
        for (int w = 1; w <= int'(ihl); w++) begin
            case (w)
                2: word = {8'd64, proto, 16'h0000};
                3: word = src;
                4: word = dst;
                default: word = (w == int'(ihl)) ? ports : $urandom; // Id, options or ports
            endcase
            put_word(word, 1'b0, int'($urandom_range(gap_max, 0)));
        end
    endtask

    task automatic end_test(input int num, input string name, input int err0);
        int wait_cnt;
        @(posedge clk);
        #2;
        {hdr_valid, hdr_sop} = 2'b00;
        wait_cnt = 0;
        while (exp_hash.size() > 0 && wait_cnt < 50) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_hash.size() > 0) begin
            $display("%0d expected results never arrived", exp_hash.size());
            errors++;
            exp_hash.delete();
            exp_queue.delete();
        end
        repeat (4) @(posedge clk); // Room for a stray strobe
        $display("test %0d %s: %0d mismatches", num, name, errors - err0);
    endtask

    always @(negedge clk) begin
        if (!rst && result_valid) begin
            if (exp_hash.size() == 0) begin
                $display("result_valid pulsed at %0d ns with no header pending", $time);
                errors++;
            end else begin
                check_val("result_hash", result_hash, exp_hash.pop_front());
                check_val("result_queue", 32'(result_queue), 32'(exp_queue.pop_front()));
            end
        end
        if (wb_ack) begin
            ack_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run passed the %0d cycle limit and was stopped", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        int          err0;
        int          ack0;
        int          pick;
        void'($urandom(32'h4032e0d1));
        {hdr_data, hdr_valid, hdr_sop, wb_cyc, wb_stb, wb_we, wb_adr, wb_wdata} = '0;
        {errors, ack_count, cycles} = '0;
        key_model = '0;
        foreach (tbl_model[i]) tbl_model[i] = '0;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        err0 = errors;
        ack0 = ack_count;
        for (int n = 0; n < `RSS_KEY_WORDS; n++) begin
            wb_xfer(1'b1, 8'(n), KEY[KEY_TOP - 32 * n -: 32], rdata);
        end
        key_model = KEY;
        for (int n = 0; n < `RSS_KEY_WORDS; n++) begin
            wb_xfer(1'b0, 8'(n), 32'h0, rdata);
            check_val("wb_rdata", rdata, key_model[KEY_TOP - 32 * n -: 32]);
        end
        wb_xfer(1'b0, 8'd64, 32'h0, rdata); // Table words read as zero
        check_val("wb_rdata", rdata, 32'h0);
        repeat (2) @(posedge clk);
        check_val("wb_ack count", ack_count - ack0, 2 * `RSS_KEY_WORDS + 1);
        end_test(1, "key write and read back", err0);

        err0 = errors;
        send_hdr(4'd4, 4'd5, 8'd6, 32'h420995bb, 32'ha18e6450, {16'd2794, 16'd1766}, 0);
        send_hdr(4'd4, 4'd5, 8'd17, 32'hc0a80001, 32'h0a000002, 32'h1f900035, 1);
        end_test(2, "tcp and udp with ihl 5", err0);

        err0 = errors;
        send_hdr(4'd4, 4'd5, 8'd1, 32'h0a010203, 32'h0a040506, 32'h12345678, 1);
        send_hdr(4'd6, 4'd5, 8'd6, 32'h01020304, 32'h05060708, 32'h9abcdef0, 0);
        end_test(3, "icmp and version 6", err0);

        err0 = errors;
        send_hdr(4'd4, 4'd7, 8'd6, 32'hac100a01, 32'hac100a63, 32'hc35001bb, 1);
        end_test(4, "ports after options", err0);

        err0 = errors;
        for (int i = 0; i < (1 << `RSS_TBL_BITS); i++) begin
            tbl_model[i] = $urandom_range((1 << `RSS_QUEUE_BITS) - 1, 0);
            wb_xfer(1'b1, 8'(64 + i), 32'(tbl_model[i]), rdata);
        end
        for (int i = 0; i < 4; i++) begin
            send_hdr(4'd4, 4'd5, 8'd6, $urandom, $urandom, $urandom, 0);
        end
        end_test(5, "queue from table", err0);

        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            pick = $urandom_range(2, 0);
            send_hdr(4'd4, 4'(5 + $urandom_range(3, 0)),
                     (pick == 0) ? 8'd6 : (pick == 1) ? 8'd17 : 8'd1,
                     $urandom, $urandom, $urandom, 2);
        end
        end_test(6, "random headers", err0);

        $display("tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the RSS hash unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
if ! verilator --binary --assert -Wno-fatal -f files.f --top-module rss_tb -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi
# An aborted run, for example on a failed assertion, counts as a failure
if ! ./obj_dir/Vrss_tb > "$LOG" 2>&1; then
    echo "ERRORS FOUND" >> "$LOG"
fi
cat "$LOG"
if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- tuple_extract.sv
// IPv4 tuple extractor
// Counts header words from start of packet, keeps version, IHL and protocol,
// and feeds source address, destination address and, for TCP and UDP,
// the port word to the hash accumulator in the same cycle as the input beat
`timescale 1ns/1ps

module tuple_extract (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] hdr_data,
    input  logic        hdr_valid,
    input  logic        hdr_sop,
    hash_feed_if.src    feed
);

    rss_pkg::ipv4_word_u hw; // Current header word, decoded per its index

    logic [3:0] cnt_q;  // Index of the next expected header word
    logic [3:0] idx;    // Index of the word on the input this cycle
    logic [3:0] ver_q;
    logic [3:0] ihl_q;
    logic       l4_q;   // Header carries TCP or UDP
    logic       done_q; // Tuple finished or header rejected
    logic       live;   // Beat inside a version 4 header still being parsed
    logic       addr_beat;
    logic       port_beat;
    logic       last_beat;

    assign hw  = hdr_data;
    assign idx = hdr_sop ? 4'd0 : cnt_q;

    assign live      = hdr_valid && !hdr_sop && (ver_q == 4'd4) && !done_q;
    assign addr_beat = live && (idx == 4'd3 || idx == 4'd4); // Source then destination
    // Ports sit right after the options, at word IHL
    assign port_beat = live && l4_q && (ihl_q > 4'd4) && (idx == ihl_q);
    assign last_beat = (addr_beat && idx == 4'd4 && !l4_q) || port_beat;

    // Network byte order with the first byte in the lowest lane
    assign feed.data  = {hdr_data[7:0], hdr_data[15:8], hdr_data[23:16], hdr_data[31:24]};
    assign feed.len   = rss_pkg::LEN4;
    assign feed.valid = addr_beat || port_beat;
    assign feed.clear = hdr_valid && hdr_sop; // Empties the accumulator for the new header
    assign feed.last  = last_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q  <= '0;
            ver_q  <= '0;
            ihl_q  <= '0;
            l4_q   <= 1'b0;
            done_q <= 1'b1; // Nothing is parsed until the first start of packet
        end else if (hdr_valid) begin
            cnt_q <= (idx == 4'd15) ? 4'd15 : idx + 4'd1; // Saturate past the longest header
            if (hdr_sop) begin
                ver_q  <= hw.w0.version;
                ihl_q  <= hw.w0.ihl;
                l4_q   <= 1'b0;
                done_q <= 1'b0;
            end else if (idx == 4'd2) begin
                l4_q <= (hw.w2.protocol == rss_pkg::PROTO_TCP) ||
                        (hw.w2.protocol == rss_pkg::PROTO_UDP);
            end
            if (last_beat) begin
                done_q <= 1'b1; // Later words of this header are payload to us
            end
        end
    end

endmodule
